/* hw/fir_pkg.sv */
package fir_pkg;

    // widths
    localparam int DATA_W           = 32;
    localparam int ADDR_W           = 12;
    localparam int NUM_TAPS_DEFAULT = 11;

    typedef logic signed [DATA_W-1:0] sample_t;   // stream sample or result
    typedef logic signed [DATA_W-1:0] coef_t;
    typedef logic [ADDR_W-1:0]        reg_addr_t;
    typedef logic [31:0]              count_t;    // samples per run

    // register map
    localparam reg_addr_t ADDR_AP_CTRL   = 12'h000;
    localparam reg_addr_t ADDR_DATA_LEN  = 12'h010;
    localparam reg_addr_t ADDR_COEF_BASE = 12'h020;   // coefficient k at base + 4*k

    // control word bits
    localparam int AP_START_BIT = 0;
    localparam int AP_DONE_BIT  = 1;
    localparam int AP_IDLE_BIT  = 2;

    typedef enum logic [1:0] {
        IDLE,     // waiting for ap_start
        RUN,      // taking input samples
        DRAIN     // last sample in, waiting for the last output
    } run_state_t;

endpackage

/* hw/fir_tap_if.sv */
`timescale 1ns/1ps

interface fir_tap_if import fir_pkg::*; ();

    logic    shift;         // sample accepted this cycle
    logic    clear;         // run start, zero the history
    sample_t sample_in;     // new sample for tap 0, previous tap's sample otherwise
    sample_t sample_q;
    logic    coef_we;
    coef_t   coef_wdata;
    coef_t   coef_q;
    sample_t product;
    logic    hold;          // output stalled

    modport ctrl (
        output shift,
        output clear,
        output sample_in,
        output coef_we,
        output coef_wdata,
        input  coef_q
    );

    modport tap (
        input  shift,
        input  clear,
        input  sample_in,
        input  coef_we,
        input  coef_wdata,
        input  hold,
        output sample_q,
        output coef_q,
        output product
    );

    modport accum (
        input  shift,
        input  product,
        output hold
    );

endinterface

/* hw/fir_ctrl.sv */
`timescale 1ns/1ps

module fir_ctrl import fir_pkg::*; #(
    parameter int NUM_TAPS = NUM_TAPS_DEFAULT
) (
    input  logic              axis_clk,
    input  logic              axis_rst_n,
    // register write
    input  logic              awvalid,
    input  reg_addr_t         awaddr,
    output logic              awready,
    input  logic              wvalid,
    input  logic [DATA_W-1:0] wdata,
    output logic              wready,
    // register read
    input  logic              arvalid,
    input  reg_addr_t         araddr,
    output logic              arready,
    output logic              rvalid,
    output logic [DATA_W-1:0] rdata,
    input  logic              rready,
    // input stream
    input  logic              ss_tvalid,
    input  sample_t           ss_tdata,
    input  logic              ss_tlast,     // ignored as the count ends a run
    output logic              ss_tready,
    // pipeline
    input  logic              stall,
    input  logic              out_done,
    output logic              in_last,
    fir_tap_if.ctrl           taps [NUM_TAPS]
);

    localparam int IDX_W = (NUM_TAPS > 1) ? $clog2(NUM_TAPS) : 1;

    run_state_t        state;
    logic              ap_start;
    logic              ap_done;
    logic              ap_idle;
    count_t            data_len;
    count_t            in_cnt;      // samples taken so far
    logic              wr_rdy;
    logic              wr_hs;
    logic              rd_hs;
    logic              accept;
    logic              run_go;
    reg_addr_t         rd_off;
    logic              coef_hit;
    logic [IDX_W-1:0]  rd_idx;
    coef_t             coef_rd [NUM_TAPS];
    logic [DATA_W-1:0] rd_mux;

    assign awready = wr_rdy;
    assign wready  = wr_rdy;
    assign wr_hs   = wr_rdy && awvalid && wvalid;
    assign arready = !rvalid;       // one read outstanding at most
    assign rd_hs   = arvalid && arready;

    assign run_go    = (state == IDLE) && ap_start;
    assign ss_tready = (state == RUN) && (in_cnt != data_len) && !stall;
    assign accept    = ss_tvalid && ss_tready;
    assign in_last   = accept && (in_cnt + 32'd1 == data_len);

    // tap fan-out
    assign taps[0].sample_in = ss_tdata;

    for (genvar k = 0; k < NUM_TAPS; k++) begin : g_tap
        assign taps[k].shift      = accept;
        assign taps[k].clear      = run_go;
        assign taps[k].coef_we    = wr_hs &&
                                    (awaddr == reg_addr_t'(ADDR_COEF_BASE + 4 * k));
        assign taps[k].coef_wdata = wdata;
        assign coef_rd[k]         = taps[k].coef_q;
    end

    // read decode
    assign rd_off   = araddr - ADDR_COEF_BASE;
    assign rd_idx   = rd_off[IDX_W+1:2];
    assign coef_hit = (araddr >= ADDR_COEF_BASE) && (rd_off[1:0] == 2'b00) &&
                      ((rd_off >> 2) < NUM_TAPS);

    always_comb begin
        rd_mux = '0;
        if (araddr == ADDR_AP_CTRL) begin
            rd_mux[AP_START_BIT] = ap_start;
            rd_mux[AP_DONE_BIT]  = ap_done;
            rd_mux[AP_IDLE_BIT]  = ap_idle;
        end else if (araddr == ADDR_DATA_LEN) begin
            rd_mux = data_len;
        end else if (coef_hit) begin
            rd_mux = coef_rd[rd_idx];
        end
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            wr_rdy <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            // one-cycle ready pulse while nothing is running
            wr_rdy <= !wr_rdy && awvalid && wvalid && (state == IDLE) && !ap_start;
            if (rd_hs) begin
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        if (rd_hs) begin
            rdata <= rd_mux;    // held until rready
        end
    end

    // run FSM and status bits
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state    <= IDLE;
            ap_start <= 1'b0;
            ap_done  <= 1'b0;
            ap_idle  <= 1'b1;
            data_len <= '0;
            in_cnt   <= '0;
        end else begin
            if (wr_hs && awaddr == ADDR_AP_CTRL) begin
                ap_start <= wdata[AP_START_BIT];    // done and idle are status only
            end
            if (wr_hs && awaddr == ADDR_DATA_LEN) begin
                data_len <= wdata;
            end
            if (rd_hs && araddr == ADDR_AP_CTRL) begin
                ap_done <= 1'b0;    // cleared by a status read
            end

            case (state)
                IDLE: begin
                    if (run_go) begin
                        state    <= RUN;
                        ap_start <= 1'b0;
                        ap_idle  <= 1'b0;
                        in_cnt   <= '0;
                    end
                end
                RUN: begin
                    if (accept) begin
                        in_cnt <= in_cnt + 32'd1;
                        if (in_last) begin
                            state <= DRAIN;
                        end
                    end
                end
                DRAIN: begin
                    // done set here wins over a same-cycle status read
                    if (out_done) begin
                        state   <= IDLE;
                        ap_done <= 1'b1;
                        ap_idle <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // awready is registered a cycle ahead, so the handshake must still land in idle
    a_write_only_idle: assert property (
        @(posedge axis_clk) disable iff (!axis_rst_n)
        (awvalid && awready) |-> (state == IDLE && !ap_start)
    ) else $error("register write accepted while the filter is busy");

endmodule

/* hw/fir_tap.sv */
`timescale 1ns/1ps

module fir_tap import fir_pkg::*; (
    input logic    axis_clk,
    input logic    axis_rst_n,
    fir_tap_if.tap bus
);

    sample_t prod_next;
    logic    load;

    // product of the incoming sample, which becomes sample_q on this edge
    assign prod_next = bus.coef_q * bus.sample_in;
    assign load      = bus.shift && !bus.hold;

    always_ff @(posedge axis_clk) begin
        if (bus.coef_we) begin
            bus.coef_q <= bus.coef_wdata;
        end
    end

    // delay line stage
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            bus.sample_q <= '0;
        end else if (bus.clear) begin
            bus.sample_q <= '0;     // history before a run counts as zero
        end else if (load) begin
            bus.sample_q <= bus.sample_in;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (load) begin
            bus.product <= prod_next;   // low DATA_W bits
        end
    end

    // clear comes from the start edge, shift from the input stream
    a_clear_not_shift: assert property (
        @(posedge axis_clk) disable iff (!axis_rst_n)
        !(bus.clear && bus.shift)
    ) else $error("tap clear and shift in the same cycle");

endmodule

/* hw/fir_accum.sv */
`timescale 1ns/1ps

module fir_accum import fir_pkg::*; #(
    parameter int NUM_TAPS = NUM_TAPS_DEFAULT
) (
    input  logic      axis_clk,
    input  logic      axis_rst_n,
    fir_tap_if.accum  taps [NUM_TAPS],
    input  logic      in_last,
    input  logic      sm_tready,
    output logic      sm_tvalid,
    output logic      sm_tlast,
    output sample_t   sm_tdata,
    output logic      stall,
    output logic      out_done
);

    sample_t prod [NUM_TAPS];
    sample_t sum;
    logic    prod_vld;      // products hold a new sample
    logic    prod_last;

    for (genvar k = 0; k < NUM_TAPS; k++) begin : g_prod
        assign prod[k]      = taps[k].product;
        assign taps[k].hold = stall;
    end

    // adder tree wrapping at DATA_W
    always_comb begin
        sum = '0;
        for (int k = 0; k < NUM_TAPS; k++) begin
            sum = sum + prod[k];
        end
    end

    assign stall    = sm_tvalid && !sm_tready;
    assign out_done = sm_tvalid && sm_tready && sm_tlast;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            prod_vld  <= 1'b0;
            prod_last <= 1'b0;
            sm_tvalid <= 1'b0;
            sm_tlast  <= 1'b0;
        end else if (!stall) begin
            // flags follow the products one cycle behind shift
            prod_vld  <= taps[0].shift;
            prod_last <= in_last;
            sm_tvalid <= prod_vld;
            sm_tlast  <= prod_vld && prod_last;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (!stall && prod_vld) begin
            sm_tdata <= sum;
        end
    end

    // a stalled beat stays on the bus unchanged until taken
    a_hold_on_stall: assert property (
        @(posedge axis_clk) disable iff (!axis_rst_n)
        (sm_tvalid && !sm_tready) |=> (sm_tvalid && $stable(sm_tdata) && $stable(sm_tlast))
    ) else $error("output stream changed while stalled");

endmodule

/* hw/fir_top.sv */
`timescale 1ns/1ps

module fir_top import fir_pkg::*; #(
    parameter int NUM_TAPS = NUM_TAPS_DEFAULT
) (
    input  logic              axis_clk,
    input  logic              axis_rst_n,
    // register port
    input  logic              awvalid,
    input  reg_addr_t         awaddr,
    output logic              awready,
    input  logic              wvalid,
    input  logic [DATA_W-1:0] wdata,
    output logic              wready,
    input  logic              arvalid,
    input  reg_addr_t         araddr,
    output logic              arready,
    output logic              rvalid,
    output logic [DATA_W-1:0] rdata,
    input  logic              rready,
    // input stream
    input  logic              ss_tvalid,
    input  sample_t           ss_tdata,
    input  logic              ss_tlast,
    output logic              ss_tready,
    // output stream
    output logic              sm_tvalid,
    output sample_t           sm_tdata,
    output logic              sm_tlast,
    input  logic              sm_tready
);

    logic in_last;
    logic stall;
    logic out_done;

    fir_tap_if taps [NUM_TAPS] ();

    fir_ctrl #(
        .NUM_TAPS (NUM_TAPS)
    ) u_ctrl (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .awaddr     (awaddr),
        .awready    (awready),
        .wvalid     (wvalid),
        .wdata      (wdata),
        .wready     (wready),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .arready    (arready),
        .rvalid     (rvalid),
        .rdata      (rdata),
        .rready     (rready),
        .ss_tvalid  (ss_tvalid),
        .ss_tdata   (ss_tdata),
        .ss_tlast   (ss_tlast),
        .ss_tready  (ss_tready),
        .stall      (stall),
        .out_done   (out_done),
        .in_last    (in_last),
        .taps       (taps)
    );

    for (genvar k = 0; k < NUM_TAPS; k++) begin : g_tap
        if (k > 0) begin : g_chain
            assign taps[k].sample_in = taps[k-1].sample_q;  // delay line link
        end
        fir_tap u_tap (
            .axis_clk   (axis_clk),
            .axis_rst_n (axis_rst_n),
            .bus        (taps[k])
        );
    end

    fir_accum #(
        .NUM_TAPS (NUM_TAPS)
    ) u_accum (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .taps       (taps),
        .in_last    (in_last),
        .sm_tready  (sm_tready),
        .sm_tvalid  (sm_tvalid),
        .sm_tlast   (sm_tlast),
        .sm_tdata   (sm_tdata),
        .stall      (stall),
        .out_done   (out_done)
    );

endmodule

/* bench/fir_clk_gen.sv */
`timescale 1ns/1ps

module fir_clk_gen (
    output logic axis_clk,
    output logic axis_rst_n
);

    initial begin
        axis_clk = 1'b0;
        forever #5 axis_clk = ~axis_clk;    // 10 ns period
    end

    initial begin
        axis_rst_n = 1'b0;
        repeat (5) @(posedge axis_clk);
        #1 axis_rst_n = 1'b1;   // released just after the fifth edge
    end

endmodule

/* bench/fir_tb.sv */
`timescale 1ns/1ps

module fir_tb import fir_pkg::*; ();

    localparam int NUM_TAPS        = NUM_TAPS_DEFAULT;
    localparam int RUN_LEN         = 24;
    localparam int NUM_RUNS        = 2;
    localparam int WATCHDOG_CYCLES = NUM_RUNS * RUN_LEN * 20 + 2000;
    localparam logic [31:0] ST_IDLE      = 32'(1 << AP_IDLE_BIT);
    localparam logic [31:0] ST_DONE_IDLE = 32'((1 << AP_IDLE_BIT) | (1 << AP_DONE_BIT));

    logic              axis_clk;
    logic              axis_rst_n;
    logic              awvalid;
    reg_addr_t         awaddr;
    logic              awready;
    logic              wvalid;
    logic [DATA_W-1:0] wdata;
    logic              wready;
    logic              arvalid;
    reg_addr_t         araddr;
    logic              arready;
    logic              rvalid;
    logic [DATA_W-1:0] rdata;
    logic              rready;
    logic              ss_tvalid;
    sample_t           ss_tdata;
    logic              ss_tlast;
    logic              ss_tready;
    logic              sm_tvalid;
    sample_t           sm_tdata;
    logic              sm_tlast;
    logic              sm_tready;

    logic              busy;        // a run is in progress
    logic              rd_check;
    logic              reset_check;
    logic [DATA_W-1:0] rd_exp;
    int                out_cnt;     // outputs taken in the current run
    logic [31:0]       lcg_state;
    coef_t             coef_val [NUM_TAPS];
    sample_t           run_samples [RUN_LEN];
    sample_t           exp_mem [RUN_LEN];
    sample_t           exp_data;
    sample_t           first_exp;
    logic              exp_last;

    assign exp_data  = exp_mem[out_cnt];
    assign exp_last  = (out_cnt == RUN_LEN - 1);
    assign first_exp = coef_val[0] * run_samples[0];    // fresh history so only h0*x0 counts

    fir_clk_gen u_clk_gen (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n)
    );

    fir_top #(
        .NUM_TAPS (NUM_TAPS)
    ) fir_top_i (.*);

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic next_cycle();
        @(posedge axis_clk);
        #1;
    endtask

    task automatic reg_write(input reg_addr_t addr, input logic [DATA_W-1:0] data);
        awvalid = 1'b1;
        wvalid  = 1'b1;
        awaddr  = addr;
        wdata   = data;
        while (!awready) next_cycle();
        next_cycle();   // handshake edge
        awvalid = 1'b0;
        wvalid  = 1'b0;
    endtask

    task automatic reg_read(input reg_addr_t addr, input logic [DATA_W-1:0] expected);
        rd_exp   = expected;
        rd_check = 1'b1;
        arvalid  = 1'b1;
        araddr   = addr;
        while (!arready) next_cycle();
        next_cycle();
        arvalid = 1'b0;
        while (!rvalid) next_cycle();
        next_cycle();   // rready is always high, so the data is checked on this edge
        rd_check = 1'b0;
    endtask

    // direct convolution with zero history before the first sample
    task automatic build_expected();
        sample_t hist[$];
        sample_t acc;
        for (int i = 0; i < RUN_LEN; i++) begin
            hist.push_front(run_samples[i]);
            acc = '0;
            for (int k = 0; k < NUM_TAPS && k < hist.size(); k++) begin
                acc = acc + coef_val[k] * hist[k];
            end
            exp_mem[i] = acc;
        end
    endtask

    task automatic feed_samples();
        for (int i = 0; i < RUN_LEN; i++) begin
            ss_tvalid = 1'b1;
            ss_tdata  = run_samples[i];
            ss_tlast  = (i == RUN_LEN - 1);
            do @(negedge axis_clk); while (!ss_tready);
            next_cycle();
        end
        ss_tvalid = 1'b0;
        ss_tlast  = 1'b0;
        awvalid   = 1'b0;   // pending write gives up before the run ends
        wvalid    = 1'b0;
    endtask

    task automatic drain_outputs(input bit random_ready);
        int          taken;
        logic        hs;
        logic [31:0] r;
        taken = 0;
        while (taken < RUN_LEN) begin
            r = lcg_next();
            sm_tready = random_ready ? (r[31:30] != 2'b00) : 1'b1;
            @(negedge axis_clk);
            hs = sm_tvalid && sm_tready;
            next_cycle();
            if (hs) begin
                taken++;
                out_cnt++;
            end
        end
        sm_tready = 1'b0;
    endtask

    task automatic run_filter(input bit random_ready);
        for (int i = 0; i < RUN_LEN; i++) begin
            run_samples[i] = sample_t'(lcg_next());
        end
        build_expected();
        out_cnt = 0;
        reg_write(ADDR_DATA_LEN, RUN_LEN);
        reg_write(ADDR_AP_CTRL, 32'h1);
        busy    = 1'b1;
        awaddr  = ADDR_DATA_LEN;    // this write must be held off until idle
        wdata   = 32'h5;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        fork
            feed_samples();
            drain_outputs(random_ready);
        join
        busy = 1'b0;
    endtask

    a_reset_state: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        reset_check |-> ({awready, wready, rvalid, ss_tready, sm_tvalid, sm_tlast, arready}
                         == 7'h01))
        else stop_on_error($sformatf("ERROR: {awready,wready,rvalid,ss_tready,sm_tvalid,%s",
            $sformatf("sm_tlast,arready} got %h expected 01", $sampled({awready, wready,
            rvalid, ss_tready, sm_tvalid, sm_tlast, arready}))));

    a_read_data: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        (rd_check && rvalid && rready) |-> (rdata == rd_exp))
        else stop_on_error($sformatf("ERROR: rdata got %h expected %h",
            $sampled(rdata), $sampled(rd_exp)));

    a_out_data: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        (sm_tvalid && sm_tready) |-> (sm_tdata == exp_data))
        else stop_on_error($sformatf("ERROR: sm_tdata got %h expected %h",
            $sampled(sm_tdata), $sampled(exp_data)));

    a_first_out: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        (sm_tvalid && sm_tready && out_cnt == 0) |-> (sm_tdata == first_exp))
        else stop_on_error($sformatf("ERROR: first sm_tdata got %h expected %h",
            $sampled(sm_tdata), $sampled(first_exp)));

    a_out_last: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        (sm_tvalid && sm_tready) |-> (sm_tlast == exp_last))
        else stop_on_error($sformatf("ERROR: sm_tlast got %h expected %h",
            $sampled(sm_tlast), $sampled(exp_last)));

    a_out_stable: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        (sm_tvalid && !sm_tready) |=> (sm_tvalid && $stable(sm_tdata) && $stable(sm_tlast)))
        else stop_on_error($sformatf("ERROR: sm_tdata moved while stalled, was %h now %h",
            $past(sm_tdata), $sampled(sm_tdata)));

    a_busy_no_write: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        busy |-> (!awready && !wready))
        else stop_on_error($sformatf("ERROR: awready got %h expected 0 while busy",
            $sampled(awready)));

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge axis_clk);
        stop_on_error("timeout: the test sequence did not finish in time");
    end

    initial begin
        awvalid     = 1'b0;
        awaddr      = '0;
        wvalid      = 1'b0;
        wdata       = '0;
        arvalid     = 1'b0;
        araddr      = '0;
        rready      = 1'b1;
        ss_tvalid   = 1'b0;
        ss_tdata    = '0;
        ss_tlast    = 1'b0;
        sm_tready   = 1'b0;
        busy        = 1'b0;
        rd_check    = 1'b0;
        reset_check = 1'b0;
        rd_exp      = '0;
        out_cnt     = 0;
        lcg_state   = 32'd1723;
        @(posedge axis_rst_n);
        reset_check = 1'b1;
        next_cycle();
        reset_check = 1'b0;
        reg_read(ADDR_AP_CTRL, ST_IDLE);
        for (int k = 0; k < NUM_TAPS; k++) begin
            coef_val[k] = coef_t'(lcg_next());
            reg_write(reg_addr_t'(ADDR_COEF_BASE + 4 * k), coef_val[k]);
        end
        for (int k = 0; k < NUM_TAPS; k++) begin
            reg_read(reg_addr_t'(ADDR_COEF_BASE + 4 * k), coef_val[k]);
        end
        run_filter(1'b0);
        reg_read(ADDR_AP_CTRL, ST_DONE_IDLE);
        reg_read(ADDR_AP_CTRL, ST_IDLE);     // done cleared by the previous read
        run_filter(1'b1);                    // random back-pressure
        reg_read(ADDR_AP_CTRL, ST_DONE_IDLE);
        reg_read(ADDR_AP_CTRL, ST_IDLE);
        reg_read(ADDR_DATA_LEN, RUN_LEN);    // busy write was refused
        $display("All tests passed");
        $finish;
    end

endmodule

/* compile.f */
hw/fir_pkg.sv
hw/fir_tap_if.sv
hw/fir_ctrl.sv
hw/fir_tap.sv
hw/fir_accum.sv
hw/fir_top.sv
bench/fir_clk_gen.sv
bench/fir_tb.sv
